//--- trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Trace record widths
// ---------------------------------------------------------------------------
`define TRACE_PC_WIDTH   64
`define TRACE_WORD_WIDTH 32
`define TRACE_META_WIDTH 4

// Number of application cores feeding the snooper
`define TRACE_NUM_CORES  2

// ---------------------------------------------------------------------------
// Record queue
// ---------------------------------------------------------------------------
`define TRACE_FIFO_DEPTH 8
// Fill level that raises the interrupt
`define TRACE_WATERMARK  6

`endif

//--- cfi_trace_pkg.sv
`default_nettype none

`include "trace_settings.svh"

package cfi_trace_pkg;

  // RISC-V privilege encoding without the hypervisor level
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // ---------------------------------------------------------------------------
  // Raw record as emitted by one core
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [`TRACE_PC_WIDTH-1:0]   pc_src;
    logic [`TRACE_PC_WIDTH-1:0]   pc_dst;
    logic [`TRACE_META_WIDTH-1:0] metadata;
    priv_lvl_t                    priv_lvl;
    logic [`TRACE_WORD_WIDTH-1:0] instr;
  } core_trace_t;

  // ---------------------------------------------------------------------------
  // Record in snooper word layout
  // ---------------------------------------------------------------------------
  typedef struct packed {
    priv_lvl_t                    priv_lvl;
    logic [`TRACE_WORD_WIDTH-1:0] pc_src_h;
    logic [`TRACE_WORD_WIDTH-1:0] pc_src_l;
    logic [`TRACE_WORD_WIDTH-1:0] pc_dst_h;
    logic [`TRACE_WORD_WIDTH-1:0] pc_dst_l;
    logic [`TRACE_WORD_WIDTH-1:0] metadata;
    logic [`TRACE_WORD_WIDTH-1:0] opcode;
  } trace_rec_t;

  // Queue fill level from 0 up to full depth
  typedef logic [$clog2(`TRACE_FIFO_DEPTH+1)-1:0] fill_t;

endpackage

`default_nettype wire

//--- trace_select_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_select_stage (
  input  wire logic                       clk_i,
  input  wire logic                       ndmreset_n,
  input  wire cfi_trace_pkg::core_trace_t core0_trace_i,
  input  wire cfi_trace_pkg::core_trace_t core1_trace_i,
  input  wire logic                       core0_valid_i,
  input  wire logic                       core1_valid_i,
  input  wire logic                       core_select_i,
  output logic                            sel_valid_o,
  output cfi_trace_pkg::core_trace_t      sel_trace_o
);

  cfi_trace_pkg::core_trace_t  core_trace [`TRACE_NUM_CORES];
  logic [`TRACE_NUM_CORES-1:0] core_valid;
  logic                        watched_valid;
  cfi_trace_pkg::core_trace_t  watched_trace;

  logic                        sel_valid_q;
  cfi_trace_pkg::core_trace_t  sel_trace_q;

  // ---------------------------------------------------------------------------
  // Core mux
  // ---------------------------------------------------------------------------
  assign core_trace[0] = core0_trace_i;
  assign core_trace[1] = core1_trace_i;
  assign core_valid    = {core1_valid_i, core0_valid_i};

  // Unwatched core is simply ignored
  assign watched_valid = core_valid[core_select_i];
  assign watched_trace = core_trace[core_select_i];

  // ---------------------------------------------------------------------------
  // Stage register
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sel_valid_q <= 1'b0;
    end else begin
      sel_valid_q <= watched_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (watched_valid) begin
      sel_trace_q <= watched_trace;
    end
  end

  assign sel_valid_o = sel_valid_q;
  assign sel_trace_o = sel_trace_q;

endmodule

`default_nettype wire

//--- trace_format_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_format_stage (
  input  wire logic                       clk_i,
  input  wire logic                       ndmreset_n,
  input  wire logic                       sel_valid_i,
  input  wire cfi_trace_pkg::core_trace_t sel_trace_i,
  output logic                            fmt_valid_o,
  output cfi_trace_pkg::trace_rec_t       fmt_rec_o
);

  localparam int unsigned PcW   = `TRACE_PC_WIDTH;
  localparam int unsigned WordW = `TRACE_WORD_WIDTH;
  localparam int unsigned MetaW = `TRACE_META_WIDTH;

  cfi_trace_pkg::trace_rec_t fmt_rec_d;
  cfi_trace_pkg::trace_rec_t fmt_rec_q;
  logic                      fmt_valid_q;

  // Upper word with the top bit cleared for the snooper
  function automatic logic [WordW-1:0] pc_high(input logic [PcW-1:0] pc);
    return {1'b0, pc[PcW-2:WordW]};
  endfunction

  // Lower word with the meaningless bit 0 cleared
  function automatic logic [WordW-1:0] pc_low(input logic [PcW-1:0] pc);
    return {pc[WordW-1:1], 1'b0};
  endfunction

  // ---------------------------------------------------------------------------
  // Snooper word layout
  // ---------------------------------------------------------------------------
  always_comb begin
    fmt_rec_d.priv_lvl = sel_trace_i.priv_lvl;
    fmt_rec_d.pc_src_h = pc_high(sel_trace_i.pc_src);
    fmt_rec_d.pc_src_l = pc_low(sel_trace_i.pc_src);
    fmt_rec_d.pc_dst_h = pc_high(sel_trace_i.pc_dst);
    fmt_rec_d.pc_dst_l = pc_low(sel_trace_i.pc_dst);
    fmt_rec_d.metadata = {{(WordW-MetaW){1'b0}}, sel_trace_i.metadata};
    fmt_rec_d.opcode   = sel_trace_i.instr;
  end

  // ---------------------------------------------------------------------------
  // Stage register
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      fmt_valid_q <= 1'b0;
    end else begin
      fmt_valid_q <= sel_valid_i;
    end
  end

  // Payload holds between records
  always_ff @(posedge clk_i) begin
    if (sel_valid_i) begin
      fmt_rec_q <= fmt_rec_d;
    end
  end

  assign fmt_valid_o = fmt_valid_q;
  assign fmt_rec_o   = fmt_rec_q;

endmodule

`default_nettype wire

//--- trace_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_fifo (
  input  wire logic                      clk_i,
  input  wire logic                      ndmreset_n,
  input  wire logic                      wr_valid_i,
  input  wire cfi_trace_pkg::trace_rec_t wr_rec_i,
  input  wire logic                      pop_i,
  output cfi_trace_pkg::trace_rec_t      rec_o,
  output logic                           rec_valid_o,
  output cfi_trace_pkg::fill_t           fill_o,
  output logic                           watermark_irq_o,
  output logic                           overflow_o
);

  localparam int unsigned Depth = `TRACE_FIFO_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  localparam cfi_trace_pkg::fill_t DepthFill = cfi_trace_pkg::fill_t'(Depth);
  localparam cfi_trace_pkg::fill_t Watermark = cfi_trace_pkg::fill_t'(`TRACE_WATERMARK);
  localparam logic [PtrW-1:0]      LastPtr   = PtrW'(Depth - 1);

  cfi_trace_pkg::trace_rec_t mem_q [Depth];

  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  cfi_trace_pkg::fill_t count_q;
  cfi_trace_pkg::fill_t count_d;

  logic empty;
  logic full;
  logic do_pop;
  logic do_push;
  logic drop;

  logic watermark_q;
  logic overflow_q;

  // Wrap explicitly so any depth works
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == LastPtr) ? '0 : ptr + 1'b1;
  endfunction

  // ---------------------------------------------------------------------------
  // Push / pop decisions
  // ---------------------------------------------------------------------------
  assign empty   = (count_q == '0);
  assign full    = (count_q == DepthFill);

  // Pop on empty is a no-op
  assign do_pop  = pop_i && !empty;
  // A pop in the same cycle frees the slot
  assign do_push = wr_valid_i && (!full || do_pop);
  assign drop    = wr_valid_i && !do_push;

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Pointers, count and flags
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      watermark_q <= 1'b0;
      overflow_q  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q     <= count_d;
      // level follows the fill count one cycle behind
      watermark_q <= (count_q >= Watermark);
      // Sticky until reset
      overflow_q  <= overflow_q | drop;
    end
  end

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wr_rec_i;
    end
  end

  // First-word fall-through head
  assign rec_o           = mem_q[rd_ptr_q];
  assign rec_valid_o     = !empty;
  assign fill_o          = count_q;
  assign watermark_irq_o = watermark_q;
  assign overflow_o      = overflow_q;

endmodule

`default_nettype wire

//--- cfi_trace_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfi_trace_top (
  input  wire logic                       clk_i,
  input  wire logic                       ndmreset_n,
  input  wire cfi_trace_pkg::core_trace_t core0_trace_i,
  input  wire cfi_trace_pkg::core_trace_t core1_trace_i,
  input  wire logic                       core0_valid_i,
  input  wire logic                       core1_valid_i,
  input  wire logic                       core_select_i,
  input  wire logic                       pop_i,
  output cfi_trace_pkg::trace_rec_t       rec_o,
  output logic                            rec_valid_o,
  output cfi_trace_pkg::fill_t            fill_o,
  output logic                            watermark_irq_o,
  output logic                            overflow_o
);

  logic                       sel_valid;
  cfi_trace_pkg::core_trace_t sel_trace;
  logic                       fmt_valid;
  cfi_trace_pkg::trace_rec_t  fmt_rec;

  // ---------------------------------------------------------------------------
  // Stage 1 picks the watched core
  // ---------------------------------------------------------------------------
  trace_select_stage u_select (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .core0_trace_i ( core0_trace_i ),
    .core1_trace_i ( core1_trace_i ),
    .core0_valid_i ( core0_valid_i ),
    .core1_valid_i ( core1_valid_i ),
    .core_select_i ( core_select_i ),
    .sel_valid_o   ( sel_valid     ),
    .sel_trace_o   ( sel_trace     )
  );

  // ---------------------------------------------------------------------------
  // Stage 2 packs the snooper word layout
  // ---------------------------------------------------------------------------
  trace_format_stage u_format (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .sel_valid_i ( sel_valid  ),
    .sel_trace_i ( sel_trace  ),
    .fmt_valid_o ( fmt_valid  ),
    .fmt_rec_o   ( fmt_rec    )
  );

  // ---------------------------------------------------------------------------
  // Stage 3 queues the records
  // ---------------------------------------------------------------------------
  trace_fifo u_fifo (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .wr_valid_i      ( fmt_valid       ),
    .wr_rec_i        ( fmt_rec         ),
    .pop_i           ( pop_i           ),
    .rec_o           ( rec_o           ),
    .rec_valid_o     ( rec_valid_o     ),
    .fill_o          ( fill_o          ),
    .watermark_irq_o ( watermark_irq_o ),
    .overflow_o      ( overflow_o      )
  );

endmodule

`default_nettype wire

//--- trace_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_checker (
  input  wire logic                 clk_i,
  input  wire logic                 ndmreset_n,
  input  wire logic                 rec_valid_i,
  input  wire cfi_trace_pkg::fill_t fill_i,
  input  wire logic                 watermark_irq_i,
  input  wire logic                 overflow_i
);

  localparam cfi_trace_pkg::fill_t Watermark = cfi_trace_pkg::fill_t'(`TRACE_WATERMARK);

  int fail_count = 0;

  // Head is only shown when something is stored
  a_valid_needs_fill: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
      (fill_i == '0) |-> !rec_valid_i)
    else begin
      fail_count = fail_count + 1;
      $error("rec_valid_o is high while fill_o is zero");
    end

  // Overflow is sticky
  a_overflow_sticky: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
      !$fell(overflow_i))
    else begin
      fail_count = fail_count + 1;
      $error("overflow_o fell without a reset");
    end

  // Interrupt level trails the fill count by one cycle
  a_watermark_level: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
      watermark_irq_i == ($past(fill_i) >= Watermark))
    else begin
      fail_count = fail_count + 1;
      $error("watermark_irq_o does not follow the fill level of the cycle before");
    end

endmodule

`default_nettype wire

//--- trace_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_monitor (
  input  wire logic                       clk_i,
  input  wire logic                       ndmreset_n,
  input  wire cfi_trace_pkg::core_trace_t core0_trace_i,
  input  wire cfi_trace_pkg::core_trace_t core1_trace_i,
  input  wire logic                       core0_valid_i,
  input  wire logic                       core1_valid_i,
  input  wire logic                       core_select_i,
  input  wire logic                       pop_i,
  input  wire cfi_trace_pkg::trace_rec_t  rec_i,
  input  wire logic                       rec_valid_i,
  input  wire cfi_trace_pkg::fill_t       fill_i,
  input  wire logic                       watermark_irq_i,
  input  wire logic                       overflow_i
);

  cfi_trace_pkg::trace_rec_t  exp_q [$];
  cfi_trace_pkg::trace_rec_t  exp_rec;
  cfi_trace_pkg::core_trace_t sel_m;
  cfi_trace_pkg::trace_rec_t  fmt_m;
  logic sel_v_m;
  logic fmt_v_m;
  logic exp_wm;
  logic exp_ovf;
  int   pre_fill;

  int error_count     = 0;
  int records_checked = 0;
  int errors_seen     = 0;
  int records_seen    = 0;
  int test_count      = 0;
  int failed_tests    = 0;

  // Expected snooper words for one raw record
  function automatic cfi_trace_pkg::trace_rec_t expect_format(
      input cfi_trace_pkg::core_trace_t raw);
    cfi_trace_pkg::trace_rec_t r;
    r.priv_lvl = raw.priv_lvl;
    r.pc_src_h = 32'(raw.pc_src >> 32) & 32'h7fff_ffff;
    r.pc_src_l = raw.pc_src[31:0] & 32'hffff_fffe;
    r.pc_dst_h = 32'(raw.pc_dst >> 32) & 32'h7fff_ffff;
    r.pc_dst_l = raw.pc_dst[31:0] & 32'hffff_fffe;
    r.metadata = 32'(raw.metadata);
    r.opcode   = raw.instr;
    return r;
  endfunction

  task automatic flag_value(input string name, input logic [255:0] exp, input logic [255:0] act);
    error_count = error_count + 1;
    $display("error: %s expected %0h got %0h at %0t", name, exp, act, $time);
  endtask

  // ---------------------------------------------------------------------------
  // Reference model stepping once per rising edge
  // ---------------------------------------------------------------------------
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      exp_q.delete();
      sel_v_m = 1'b0;
      fmt_v_m = 1'b0;
      exp_wm  = 1'b0;
      exp_ovf = 1'b0;
    end else begin
      pre_fill = exp_q.size();
      if (fill_i !== cfi_trace_pkg::fill_t'(pre_fill))
        flag_value("fill_o", 256'(pre_fill), 256'(fill_i));
      if (rec_valid_i !== (pre_fill != 0))
        flag_value("rec_valid_o", 256'(pre_fill != 0), 256'(rec_valid_i));
      if (watermark_irq_i !== exp_wm)
        flag_value("watermark_irq_o", 256'(exp_wm), 256'(watermark_irq_i));
      if (overflow_i !== exp_ovf)
        flag_value("overflow_o", 256'(exp_ovf), 256'(overflow_i));

      if (pop_i && pre_fill != 0) begin
        exp_rec = exp_q.pop_front();
        records_checked = records_checked + 1;
        if (rec_i !== exp_rec)
          flag_value("rec_o", 256'(exp_rec), 256'(rec_i));
      end
      // Pop first, so a full queue takes a write in the same cycle
      if (fmt_v_m) begin
        if (exp_q.size() < `TRACE_FIFO_DEPTH)
          exp_q.push_back(fmt_m);
        else
          exp_ovf = 1'b1;
      end
      exp_wm  = (pre_fill >= `TRACE_WATERMARK);
      fmt_v_m = sel_v_m;
      if (sel_v_m)
        fmt_m = expect_format(sel_m);
      sel_v_m = core_select_i ? core1_valid_i : core0_valid_i;
      if (sel_v_m)
        sel_m = core_select_i ? core1_trace_i : core0_trace_i;
    end
  end

  // ---------------------------------------------------------------------------
  // Reporting
  // ---------------------------------------------------------------------------
  task automatic end_test(input string name);
    int errs;
    errs = error_count - errors_seen;
    if (exp_q.size() != 0 || sel_v_m || fmt_v_m) begin
      $display("test %s ended with %0d records still undelivered", name, exp_q.size());
      errs = errs + 1;
    end
    test_count = test_count + 1;
    if (errs == 0) begin
      $display("test %0d %s: ok, %0d records checked", test_count, name,
               records_checked - records_seen);
    end else begin
      failed_tests = failed_tests + 1;
      $display("test %0d %s: %0d errors", test_count, name, errs);
    end
    errors_seen  = error_count;
    records_seen = records_checked;
  endtask

  task automatic print_summary(input int assert_fails);
    $display("summary: %0d tests, %0d failed, %0d records, %0d errors, %0d assertion failures",
             test_count, failed_tests, records_checked, error_count, assert_fails);
  endtask

endmodule

`default_nettype wire

//--- tb_cfi_trace.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfi_trace;

  typedef struct packed {
    cfi_trace_pkg::core_trace_t c0;
    cfi_trace_pkg::core_trace_t c1;
    logic                       v0;
    logic                       v1;
    logic                       sel;
    logic                       pop;
    logic [3:0]                 tag;
  } step_t;

  step_t steps [$];
  string test_names [6] = '{"reset", "core select", "format", "burst", "watermark", "overflow"};
  logic  table_ready = 1'b0;
  logic [3:0] cur_tag;

  logic                       clk_i;
  logic                       ndmreset_n;
  cfi_trace_pkg::core_trace_t core0_trace_i;
  cfi_trace_pkg::core_trace_t core1_trace_i;
  logic                       core0_valid_i;
  logic                       core1_valid_i;
  logic                       core_select_i;
  logic                       pop_i;
  cfi_trace_pkg::trace_rec_t  rec_o;
  logic                       rec_valid_o;
  cfi_trace_pkg::fill_t       fill_o;
  logic                       watermark_irq_o;
  logic                       overflow_o;

  cfi_trace_top uut (.*);

  trace_monitor mon (
    .clk_i, .ndmreset_n, .core0_trace_i, .core1_trace_i, .core0_valid_i, .core1_valid_i,
    .core_select_i, .pop_i,
    .rec_i           ( rec_o           ),
    .rec_valid_i     ( rec_valid_o     ),
    .fill_i          ( fill_o          ),
    .watermark_irq_i ( watermark_irq_o ),
    .overflow_i      ( overflow_o      )
  );

  bind cfi_trace_top trace_checker u_checker (
    .clk_i, .ndmreset_n,
    .rec_valid_i     ( rec_valid_o     ),
    .fill_i          ( fill_o          ),
    .watermark_irq_i ( watermark_irq_o ),
    .overflow_i      ( overflow_o      )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic cfi_trace_pkg::core_trace_t rand_trace(input logic force_edges);
    cfi_trace_pkg::core_trace_t t;
    t.pc_src   = {$urandom(), $urandom()};
    t.pc_dst   = {$urandom(), $urandom()};
    // Set the bits the formatter has to clear
    if (force_edges) begin
      t.pc_src = t.pc_src | 64'h8000_0000_0000_0001;
      t.pc_dst = t.pc_dst | 64'h8000_0000_0000_0001;
    end
    t.metadata = 4'($urandom());
    case ($urandom_range(2, 0))
      0:       t.priv_lvl = cfi_trace_pkg::PRIV_LVL_U;
      1:       t.priv_lvl = cfi_trace_pkg::PRIV_LVL_S;
      default: t.priv_lvl = cfi_trace_pkg::PRIV_LVL_M;
    endcase
    t.instr    = $urandom();
    return t;
  endfunction

  function automatic void add_step(input logic v0, input logic v1, input logic sel,
                                   input logic pop, input logic force_edges, input int tag);
    steps.push_back('{rand_trace(force_edges), rand_trace(force_edges), v0, v1, sel, pop,
                      4'(tag)});
  endfunction

  // ---------------------------------------------------------------------------
  // Stimulus table whose idle steps drain the 3-edge pipeline
  // ---------------------------------------------------------------------------
  function automatic void build_table();
    for (int i = 0; i < 4; i++) add_step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 0);
    for (int i = 0; i < 4; i++) add_step(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1);
    for (int i = 0; i < 4; i++) add_step(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1);
    for (int i = 0; i < 12; i++) add_step(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1);
    for (int i = 0; i < 8; i++) add_step(1'b1, 1'b1, 1'(i), 1'b1, 1'(i), 2);
    for (int i = 0; i < 6; i++) add_step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 2);
    for (int i = 0; i < 5; i++) add_step(1'b1, 1'(i), 1'b0, 1'b0, 1'b0, 3);
    for (int i = 0; i < 3; i++) add_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3);
    for (int i = 0; i < 10; i++) add_step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 3);
    for (int i = 0; i < 7; i++) add_step(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 4);
    for (int i = 0; i < 3; i++) add_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 4);
    for (int i = 0; i < 12; i++) add_step(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4);
    for (int i = 0; i < 9; i++) add_step(1'b1, 1'b0, 1'b0, 1'b0, 1'(i), 5);
    for (int i = 0; i < 3; i++) add_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5);
    for (int i = 0; i < 12; i++) add_step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 5);
  endfunction

  initial begin
    void'($urandom(75311));
    ndmreset_n    = 1'b0;
    core0_trace_i = '0;
    core1_trace_i = '0;
    core0_valid_i = 1'b0;
    core1_valid_i = 1'b0;
    core_select_i = 1'b0;
    pop_i         = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    cur_tag = steps[0].tag;
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].tag != cur_tag) begin
        @(negedge clk_i);
        mon.end_test(test_names[cur_tag]);
        cur_tag = steps[i].tag;
      end
      @(posedge clk_i);
      core0_trace_i <= steps[i].c0;
      core1_trace_i <= steps[i].c1;
      core0_valid_i <= steps[i].v0;
      core1_valid_i <= steps[i].v1;
      core_select_i <= steps[i].sel;
      pop_i         <= steps[i].pop;
    end
    @(posedge clk_i);
    core0_valid_i <= 1'b0;
    core1_valid_i <= 1'b0;
    pop_i         <= 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    mon.end_test(test_names[cur_tag]);
    mon.print_summary(uut.u_checker.fail_count);
    if (mon.error_count == 0 && mon.failed_tests == 0 && uut.u_checker.fail_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #(steps.size() * 400 + 2000);
    $display("timeout: the stimulus table did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cfi_trace_pkg.sv
trace_select_stage.sv
trace_format_stage.sv
trace_fifo.sv
cfi_trace_top.sv
trace_checker.sv
trace_monitor.sv
tb_cfi_trace.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
RUN_FLAGS  = +verilator+error+limit+1000
TOP        = tb_cfi_trace
FILELIST   = tb.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
